/* verilog/apb_demux_pkg.sv */
// APB demux shared definitions
package apb_demux_pkg;

  // bus widths, upstream and downstream alike
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // configuration space layout
  // rule n sits at n * CfgRuleStride: +0 start, +4 end, +8 idx
  localparam logic [11:0] CfgCtrlAddr   = 12'h100;
  localparam int unsigned CfgRuleStride = 16;

  // one address map entry
  // start is inclusive, end is exclusive, so an all-zero rule never matches
  typedef struct packed {
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
    logic [7:0]           idx;
  } rule_t;

  // forward stage, drives the downstream APB phases
  typedef enum logic [1:0] {
    FWD_IDLE,
    FWD_SETUP,
    FWD_ACCESS,
    FWD_DONE
  } fwd_state_e;

  // request stage, holds the upstream transfer open
  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_BUSY,
    REQ_RESP
  } req_state_e;

endpackage

/* verilog/apb_addr_decode.sv */
// Priority address decoder
`timescale 1ns/1ns

module apb_addr_decode #(
  parameter int unsigned NoPorts = 4,
  parameter int unsigned NoRules = 4,
  localparam int unsigned IdxWidth = (NoPorts > 1) ? $clog2(NoPorts) : 1
) (
  input  logic [apb_demux_pkg::AddrWidth-1:0] addr_i,
  input  apb_demux_pkg::rule_t [NoRules-1:0]  rules_i,
  input  logic                                en_default_i,
  input  logic [IdxWidth-1:0]                 default_idx_i,
  output logic [IdxWidth-1:0]                 idx_o,
  output logic                                dec_valid_o,
  output logic                                dec_error_o
);

  // per-rule range hit
  logic [NoRules-1:0] hit;

  always_comb begin
    for (int unsigned i = 0; i < NoRules; i++) begin
      // start inclusive, end exclusive
      hit[i] = (addr_i >= rules_i[i].start_addr) && (addr_i < rules_i[i].end_addr);
    end
  end

  always_comb begin
    // fallback when nothing matches
    dec_valid_o = 1'b0;
    if (en_default_i) begin
      idx_o       = default_idx_i;
      dec_error_o = 1'b0;
    end else begin
      idx_o       = '0;
      dec_error_o = 1'b1;
    end

    // scan upwards, later matches overwrite earlier ones
    // so the highest matching position wins
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (hit[i]) begin
        idx_o       = rules_i[i].idx[IdxWidth-1:0];
        dec_valid_o = 1'b1;
        dec_error_o = 1'b0;
      end
    end
  end

endmodule

/* verilog/apb_map_regs.sv */
// Address map registers
`timescale 1ns/1ns

module apb_map_regs #(
  parameter int unsigned NoPorts = 4,
  parameter int unsigned NoRules = 4,
  localparam int unsigned IdxWidth = (NoPorts > 1) ? $clog2(NoPorts) : 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   cfg_psel_i,
  input  logic                                   cfg_penable_i,
  input  logic [11:0]                            cfg_paddr_i,
  input  logic                                   cfg_pwrite_i,
  input  logic [apb_demux_pkg::DataWidth-1:0]    cfg_pwdata_i,
  output logic [apb_demux_pkg::DataWidth-1:0]    cfg_prdata_o,
  output logic                                   cfg_pslverr_o,
  output apb_demux_pkg::rule_t [NoRules-1:0]     rules_o,
  output logic                                   en_default_o,
  output logic [IdxWidth-1:0]                    default_idx_o
);

  localparam int unsigned RuleSpan = NoRules * apb_demux_pkg::CfgRuleStride;

  apb_demux_pkg::rule_t [NoRules-1:0] rules_q;
  logic                               en_default_q;
  logic [IdxWidth-1:0]                default_idx_q;

  logic       access;
  logic       rule_hit;
  logic       ctrl_hit;
  logic [7:0] rule_sel;
  logic [3:0] field;
  logic       bad_value;

  // address split: upper bits pick the rule, low nibble the field
  assign rule_sel = cfg_paddr_i[11:4];
  assign field    = cfg_paddr_i[3:0];
  assign access   = cfg_psel_i && cfg_penable_i;
  assign ctrl_hit = (cfg_paddr_i == apb_demux_pkg::CfgCtrlAddr);
  assign rule_hit = (cfg_paddr_i < RuleSpan) &&
                    ((field == 4'h0) || (field == 4'h4) || (field == 4'h8));

  // port indices at or above NoPorts are refused
  assign bad_value = (rule_hit && (field == 4'h8) && (cfg_pwdata_i >= NoPorts)) ||
                     (ctrl_hit && ({24'b0, cfg_pwdata_i[15:8]} >= NoPorts));

  // error in the access cycle only, never a wait state
  assign cfg_pslverr_o = access && (!(rule_hit || ctrl_hit) || (cfg_pwrite_i && bad_value));

  // read mux, unmapped offsets read as zero
  always_comb begin
    cfg_prdata_o = '0;
    if (ctrl_hit) begin
      cfg_prdata_o = {16'b0, 8'(default_idx_q), 7'b0, en_default_q};
    end
    for (int unsigned i = 0; i < NoRules; i++) begin
      if (rule_hit && (rule_sel == 8'(i))) begin
        case (field)
          4'h0:    cfg_prdata_o = rules_q[i].start_addr;
          4'h4:    cfg_prdata_o = rules_q[i].end_addr;
          default: cfg_prdata_o = {24'b0, rules_q[i].idx};
        endcase
      end
    end
  end

  // write path, a refused write leaves everything untouched
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rules_q       <= '0;
      en_default_q  <= 1'b0;
      default_idx_q <= '0;
    end else if (access && cfg_pwrite_i && !cfg_pslverr_o) begin
      if (ctrl_hit) begin
        en_default_q  <= cfg_pwdata_i[0];
        default_idx_q <= cfg_pwdata_i[8 +: IdxWidth];
      end
      for (int unsigned i = 0; i < NoRules; i++) begin
        if (rule_hit && (rule_sel == 8'(i))) begin
          case (field)
            4'h0:    rules_q[i].start_addr <= cfg_pwdata_i;
            4'h4:    rules_q[i].end_addr   <= cfg_pwdata_i;
            default: rules_q[i].idx        <= cfg_pwdata_i[7:0];
          endcase
        end
      end
    end
  end

  assign rules_o       = rules_q;
  assign en_default_o  = en_default_q;
  assign default_idx_o = default_idx_q;

  // the decoder truncates idx, so nothing out of range may ever get stored
  for (genvar i = 0; i < NoRules; i++) begin : g_idx_check
    a_idx_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rules_q[i].idx < NoPorts);
  end

endmodule

/* verilog/apb_req_stage.sv */
// Upstream APB request stage
`timescale 1ns/1ns

module apb_req_stage (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic [apb_demux_pkg::AddrWidth-1:0] paddr_i,
  input  logic                                pwrite_i,
  input  logic [apb_demux_pkg::DataWidth-1:0] pwdata_i,
  input  logic                                done_i,
  input  logic [apb_demux_pkg::DataWidth-1:0] rsp_rdata_i,
  input  logic                                rsp_err_i,
  output logic [apb_demux_pkg::DataWidth-1:0] prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o,
  output logic                                req_valid_o,
  output logic [apb_demux_pkg::AddrWidth-1:0] req_addr_o,
  output logic                                req_write_o,
  output logic [apb_demux_pkg::DataWidth-1:0] req_wdata_o
);

  apb_demux_pkg::req_state_e state_q;

  logic                                req_valid_q;
  logic                                err_q;
  logic [apb_demux_pkg::AddrWidth-1:0] addr_q;
  logic                                write_q;
  logic [apb_demux_pkg::DataWidth-1:0] wdata_q;
  logic [apb_demux_pkg::DataWidth-1:0] rdata_q;
  logic                                capture;
  logic                                finish;

  // setup cycle of a new upstream transfer
  assign capture = (state_q == apb_demux_pkg::REQ_IDLE) && psel_i && !penable_i;
  assign finish  = (state_q == apb_demux_pkg::REQ_BUSY) && done_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= apb_demux_pkg::REQ_IDLE;
      req_valid_q <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      // req_valid is a single-cycle pulse
      req_valid_q <= capture;
      if (capture) begin
        state_q <= apb_demux_pkg::REQ_BUSY;
      end else if (finish) begin
        state_q <= apb_demux_pkg::REQ_RESP;
        err_q   <= rsp_err_i;
      end else if (state_q == apb_demux_pkg::REQ_RESP) begin
        // response shown for exactly one cycle
        state_q <= apb_demux_pkg::REQ_IDLE;
      end
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (capture) begin
      addr_q  <= paddr_i;
      write_q <= pwrite_i;
      wdata_q <= pwdata_i;
    end
    if (finish) begin
      rdata_q <= rsp_rdata_i;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_addr_o  = addr_q;
  assign req_write_o = write_q;
  assign req_wdata_o = wdata_q;

  assign pready_o  = (state_q == apb_demux_pkg::REQ_RESP);
  assign pslverr_o = err_q;
  assign prdata_o  = rdata_q;

  // response may only land inside an open access phase
  a_pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pready_o |-> (psel_i && penable_i));

endmodule

/* verilog/apb_fwd_stage.sv */
// Downstream APB forward stage
`timescale 1ns/1ns

module apb_fwd_stage #(
  parameter int unsigned NoPorts = 4,
  localparam int unsigned IdxWidth = (NoPorts > 1) ? $clog2(NoPorts) : 1
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic                                              req_valid_i,
  input  logic [apb_demux_pkg::AddrWidth-1:0]               req_addr_i,
  input  logic                                              req_write_i,
  input  logic [apb_demux_pkg::DataWidth-1:0]               req_wdata_i,
  input  logic [IdxWidth-1:0]                               dec_idx_i,
  input  logic                                              dec_error_i,
  input  logic [NoPorts-1:0][apb_demux_pkg::DataWidth-1:0]  prdata_i,
  input  logic [NoPorts-1:0]                                pready_i,
  input  logic [NoPorts-1:0]                                pslverr_i,
  output logic [NoPorts-1:0]                                psel_o,
  output logic                                              penable_o,
  output logic [apb_demux_pkg::AddrWidth-1:0]               paddr_o,
  output logic                                              pwrite_o,
  output logic [apb_demux_pkg::DataWidth-1:0]               pwdata_o,
  output logic                                              done_o,
  output logic [apb_demux_pkg::DataWidth-1:0]               rsp_rdata_o,
  output logic                                              rsp_err_o
);

  apb_demux_pkg::fwd_state_e state_q;

  logic [IdxWidth-1:0]                 idx_q;
  logic                                err_q;
  logic [apb_demux_pkg::DataWidth-1:0] rdata_q;
  logic                                start;
  logic                                sel_ready;

  assign start     = (state_q == apb_demux_pkg::FWD_IDLE) && req_valid_i;
  // back-pressure from the selected completer only
  assign sel_ready = (state_q == apb_demux_pkg::FWD_ACCESS) && pready_i[idx_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= apb_demux_pkg::FWD_IDLE;
      idx_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        apb_demux_pkg::FWD_IDLE: begin
          if (req_valid_i) begin
            // decode result is registered here
            idx_q <= dec_idx_i;
            err_q <= dec_error_i;
            if (dec_error_i) begin
              // no match, skip the bus entirely
              state_q <= apb_demux_pkg::FWD_DONE;
            end else begin
              state_q <= apb_demux_pkg::FWD_SETUP;
            end
          end
        end
        apb_demux_pkg::FWD_SETUP: begin
          state_q <= apb_demux_pkg::FWD_ACCESS;
        end
        apb_demux_pkg::FWD_ACCESS: begin
          if (sel_ready) begin
            err_q   <= pslverr_i[idx_q];
            state_q <= apb_demux_pkg::FWD_DONE;
          end
        end
        default: begin
          state_q <= apb_demux_pkg::FWD_IDLE;
        end
      endcase
    end
  end

  // read data, zero on a decode error
  always_ff @(posedge clk_i) begin
    if (start) begin
      rdata_q <= '0;
    end else if (sel_ready) begin
      rdata_q <= prdata_i[idx_q];
    end
  end

  // one-hot select during setup and access
  always_comb begin
    psel_o = '0;
    if ((state_q == apb_demux_pkg::FWD_SETUP) || (state_q == apb_demux_pkg::FWD_ACCESS)) begin
      psel_o[idx_q] = 1'b1;
    end
  end

  assign penable_o = (state_q == apb_demux_pkg::FWD_ACCESS);
  // request stage holds these stable for the whole transfer
  assign paddr_o   = req_addr_i;
  assign pwrite_o  = req_write_i;
  assign pwdata_o  = req_wdata_i;

  assign done_o      = (state_q == apb_demux_pkg::FWD_DONE);
  assign rsp_rdata_o = rdata_q;
  assign rsp_err_o   = err_q;

  a_psel_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(psel_o));

  a_penable_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    penable_o |-> (|psel_o));

endmodule

/* verilog/apb_demux_top.sv */
// APB address demux top
`timescale 1ns/1ns

module apb_demux_top #(
  parameter int unsigned NoPorts = 4,
  parameter int unsigned NoRules = 4,
  localparam int unsigned IdxWidth = (NoPorts > 1) ? $clog2(NoPorts) : 1
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  // upstream completer port
  input  logic                                              psel_i,
  input  logic                                              penable_i,
  input  logic [apb_demux_pkg::AddrWidth-1:0]               paddr_i,
  input  logic                                              pwrite_i,
  input  logic [apb_demux_pkg::DataWidth-1:0]               pwdata_i,
  output logic [apb_demux_pkg::DataWidth-1:0]               prdata_o,
  output logic                                              pready_o,
  output logic                                              pslverr_o,
  // configuration port
  input  logic                                              cfg_psel_i,
  input  logic                                              cfg_penable_i,
  input  logic [11:0]                                       cfg_paddr_i,
  input  logic                                              cfg_pwrite_i,
  input  logic [apb_demux_pkg::DataWidth-1:0]               cfg_pwdata_i,
  output logic [apb_demux_pkg::DataWidth-1:0]               cfg_prdata_o,
  output logic                                              cfg_pslverr_o,
  // downstream requester ports
  output logic [NoPorts-1:0]                                psel_o,
  output logic                                              penable_o,
  output logic [apb_demux_pkg::AddrWidth-1:0]               paddr_o,
  output logic                                              pwrite_o,
  output logic [apb_demux_pkg::DataWidth-1:0]               pwdata_o,
  input  logic [NoPorts-1:0][apb_demux_pkg::DataWidth-1:0]  prdata_i,
  input  logic [NoPorts-1:0]                                pready_i,
  input  logic [NoPorts-1:0]                                pslverr_i
);

  apb_demux_pkg::rule_t [NoRules-1:0]  rules;
  logic                                en_default;
  logic [IdxWidth-1:0]                 default_idx;
  logic [IdxWidth-1:0]                 dec_idx;
  logic                                dec_error;
  logic                                req_valid;
  logic [apb_demux_pkg::AddrWidth-1:0] req_addr;
  logic                                req_write;
  logic [apb_demux_pkg::DataWidth-1:0] req_wdata;
  logic                                done;
  logic [apb_demux_pkg::DataWidth-1:0] rsp_rdata;
  logic                                rsp_err;

  apb_map_regs #(.NoPorts(NoPorts), .NoRules(NoRules)) i_map_regs (
    .clk_i, .rst_n_i,
    .cfg_psel_i, .cfg_penable_i, .cfg_paddr_i, .cfg_pwrite_i, .cfg_pwdata_i,
    .cfg_prdata_o, .cfg_pslverr_o,
    .rules_o       (rules),
    .en_default_o  (en_default),
    .default_idx_o (default_idx)
  );

  // decoder works on the captured address, not the live bus
  apb_addr_decode #(.NoPorts(NoPorts), .NoRules(NoRules)) i_addr_decode (
    .addr_i        (req_addr),
    .rules_i       (rules),
    .en_default_i  (en_default),
    .default_idx_i (default_idx),
    .idx_o         (dec_idx),
    .dec_valid_o   (),
    .dec_error_o   (dec_error)
  );

  apb_req_stage i_req_stage (
    .clk_i, .rst_n_i,
    .psel_i, .penable_i, .paddr_i, .pwrite_i, .pwdata_i,
    .done_i      (done),
    .rsp_rdata_i (rsp_rdata),
    .rsp_err_i   (rsp_err),
    .prdata_o, .pready_o, .pslverr_o,
    .req_valid_o (req_valid),
    .req_addr_o  (req_addr),
    .req_write_o (req_write),
    .req_wdata_o (req_wdata)
  );

  apb_fwd_stage #(.NoPorts(NoPorts)) i_fwd_stage (
    .clk_i, .rst_n_i,
    .req_valid_i (req_valid),
    .req_addr_i  (req_addr),
    .req_write_i (req_write),
    .req_wdata_i (req_wdata),
    .dec_idx_i   (dec_idx),
    .dec_error_i (dec_error),
    .prdata_i, .pready_i, .pslverr_i,
    .psel_o, .penable_o, .paddr_o, .pwrite_o, .pwdata_o,
    .done_o      (done),
    .rsp_rdata_o (rsp_rdata),
    .rsp_err_o   (rsp_err)
  );

endmodule

/* verification/tb_apb_completer.sv */
// APB memory completer model
`timescale 1ns/1ns

module tb_apb_completer #(
  parameter int unsigned PortId = 0
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                psel_i,
  input  logic                                penable_i,
  input  logic [apb_demux_pkg::AddrWidth-1:0] paddr_i,
  input  logic                                pwrite_i,
  input  logic [apb_demux_pkg::DataWidth-1:0] pwdata_i,
  output logic [apb_demux_pkg::DataWidth-1:0] prdata_o,
  output logic                                pready_o,
  output logic                                pslverr_o
);

  logic [apb_demux_pkg::DataWidth-1:0] mem [64];
  logic [1:0]                          wait_q;
  logic [7:0]                          offset;
  logic                                range_err;

  // 1 KiB window, only the first 64 words are backed by memory
  assign offset    = paddr_i[9:2];
  assign range_err = (offset >= 8'd64);

  assign pready_o  = psel_i && penable_i && (wait_q == 2'd0);
  assign pslverr_o = pready_o && range_err;
  // reads past the memory return zero
  assign prdata_o  = (pready_o && !pwrite_i && !range_err) ? mem[offset[5:0]] : '0;

  // fill pattern carries the port and the whole word index
  initial begin
    for (int unsigned i = 0; i < 64; i++) begin
      mem[i] = {8'(PortId), 8'hA5, 8'(i), ~8'(i)};
    end
  end

  // fresh wait count on every setup cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_q <= 2'd0;
    end else if (psel_i && !penable_i) begin
      wait_q <= 2'($urandom % 4);
    end else if (psel_i && penable_i && (wait_q != 2'd0)) begin
      wait_q <= wait_q - 2'd1;
    end
  end

  always @(posedge clk_i) begin
    if (pready_o && pwrite_i && !range_err) begin
      mem[offset[5:0]] <= pwdata_i;
    end
  end

endmodule

/* verification/tb_apb_demux.sv */
// APB demux testbench
`timescale 1ns/1ns

module tb_apb_demux;

  localparam int unsigned NoPorts      = 4;
  localparam int unsigned NoRules      = 4;
  localparam int unsigned AW           = apb_demux_pkg::AddrWidth;
  localparam int unsigned DW           = apb_demux_pkg::DataWidth;
  localparam int unsigned ReadyTimeout = 40;

  logic                        clk;
  logic                        rst_n;
  // upstream requester
  logic                        psel;
  logic                        penable;
  logic [AW-1:0]               paddr;
  logic                        pwrite;
  logic [DW-1:0]               pwdata;
  logic [DW-1:0]               prdata;
  logic                        pready;
  logic                        pslverr;
  // configuration requester
  logic                        cfg_psel;
  logic                        cfg_penable;
  logic [11:0]                 cfg_paddr;
  logic                        cfg_pwrite;
  logic [DW-1:0]               cfg_pwdata;
  logic [DW-1:0]               cfg_prdata;
  logic                        cfg_pslverr;
  // downstream completers
  logic [NoPorts-1:0]          ds_psel;
  logic                        ds_penable;
  logic [AW-1:0]               ds_paddr;
  logic                        ds_pwrite;
  logic [DW-1:0]               ds_pwdata;
  logic [NoPorts-1:0][DW-1:0]  ds_prdata;
  logic [NoPorts-1:0]          ds_pready;
  logic [NoPorts-1:0]          ds_pslverr;

  // reference model of the map and the completer memories
  logic [AW-1:0]               rule_start [NoRules];
  logic [AW-1:0]               rule_end [NoRules];
  logic [7:0]                  rule_idx [NoRules];
  logic                        def_en;
  logic [7:0]                  def_idx;
  logic [DW-1:0]               mem_model [NoPorts][64];
  int unsigned                 errors;
  int unsigned                 checks;
  logic                        hung;

  apb_demux_top #(.NoPorts(NoPorts), .NoRules(NoRules)) i_dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .psel_i (psel), .penable_i (penable), .paddr_i (paddr),
    .pwrite_i (pwrite), .pwdata_i (pwdata),
    .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .cfg_psel_i (cfg_psel), .cfg_penable_i (cfg_penable), .cfg_paddr_i (cfg_paddr),
    .cfg_pwrite_i (cfg_pwrite), .cfg_pwdata_i (cfg_pwdata),
    .cfg_prdata_o (cfg_prdata), .cfg_pslverr_o (cfg_pslverr),
    .psel_o (ds_psel), .penable_o (ds_penable), .paddr_o (ds_paddr),
    .pwrite_o (ds_pwrite), .pwdata_o (ds_pwdata),
    .prdata_i (ds_prdata), .pready_i (ds_pready), .pslverr_i (ds_pslverr)
  );

  for (genvar p = 0; p < NoPorts; p++) begin : g_comp
    tb_apb_completer #(.PortId(p)) i_comp (
      .clk_i (clk), .rst_n_i (rst_n),
      .psel_i (ds_psel[p]), .penable_i (ds_penable), .paddr_i (ds_paddr),
      .pwrite_i (ds_pwrite), .pwdata_i (ds_pwdata),
      .prdata_o (ds_prdata[p]), .pready_o (ds_pready[p]), .pslverr_o (ds_pslverr[p])
    );
  end

  always #10 clk = ~clk;

  function automatic logic [DW-1:0] fill_word(input int unsigned port, input int unsigned word);
    return {8'(port), 8'hA5, 8'(word), ~8'(word)};
  endfunction

  task automatic check_value(input string what, input logic [DW-1:0] actual,
                             input logic [DW-1:0] expected);
    if (hung) return;
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // one configuration transfer that always ends in its access cycle
  task automatic cfg_cycle(input logic write, input logic [11:0] addr, input logic [DW-1:0] wdata,
                           output logic [DW-1:0] rdata, output logic err);
    @(negedge clk);
    cfg_psel    = 1'b1;
    cfg_penable = 1'b0;
    cfg_paddr   = addr;
    cfg_pwrite  = write;
    cfg_pwdata  = wdata;
    @(negedge clk);
    cfg_penable = 1'b1;
    // the rising edge in between completes the access
    @(negedge clk);
    rdata       = cfg_prdata;
    err         = cfg_pslverr;
    cfg_psel    = 1'b0;
    cfg_penable = 1'b0;
  endtask

  // expected pslverr of a configuration access
  function automatic logic refused(input logic write, input logic [11:0] addr,
                                   input logic [DW-1:0] wdata);
    logic is_rule;
    logic is_ctrl;
    is_rule = (addr < 12'(NoRules * apb_demux_pkg::CfgRuleStride)) &&
              (addr[3:0] inside {4'h0, 4'h4, 4'h8});
    is_ctrl = (addr == apb_demux_pkg::CfgCtrlAddr);
    if (!is_rule && !is_ctrl) return 1'b1;
    if (write && is_rule && (addr[3:0] == 4'h8) && (wdata >= NoPorts)) return 1'b1;
    if (write && is_ctrl && (wdata[15:8] >= NoPorts)) return 1'b1;
    return 1'b0;
  endfunction

  function automatic logic [DW-1:0] reg_value(input logic [11:0] addr);
    int unsigned r;
    r = addr / apb_demux_pkg::CfgRuleStride;
    if (addr == apb_demux_pkg::CfgCtrlAddr) return {16'b0, def_idx, 7'b0, def_en};
    if (refused(1'b0, addr, '0)) return '0;
    case (addr[3:0])
      4'h0:    return rule_start[r];
      4'h4:    return rule_end[r];
      default: return {24'b0, rule_idx[r]};
    endcase
  endfunction

  task automatic mirror_write(input logic [11:0] addr, input logic [DW-1:0] wdata);
    int unsigned r;
    r = addr / apb_demux_pkg::CfgRuleStride;
    if (addr == apb_demux_pkg::CfgCtrlAddr) begin
      def_en  = wdata[0];
      def_idx = wdata[15:8];
    end else begin
      case (addr[3:0])
        4'h0:    rule_start[r] = wdata;
        4'h4:    rule_end[r]   = wdata;
        default: rule_idx[r]   = wdata[7:0];
      endcase
    end
  endtask

  task automatic reg_access(input logic write, input logic [11:0] addr,
                            input logic [DW-1:0] wdata);
    logic [DW-1:0] rdata;
    logic          err;
    logic          exp_err;
    exp_err = refused(write, addr, wdata);
    cfg_cycle(write, addr, wdata, rdata, err);
    check_value($sformatf("cfg_pslverr_o at %h", addr), 32'(err), 32'(exp_err));
    if (!write) begin
      check_value($sformatf("cfg_prdata_o at %h", addr), rdata, reg_value(addr));
    end else if (!exp_err) begin
      mirror_write(addr, wdata);
    end
  endtask

  task automatic program_rule(input int unsigned r, input logic [AW-1:0] start_addr,
                              input logic [AW-1:0] end_addr, input logic [7:0] idx);
    logic [11:0] base;
    base = 12'(r * apb_demux_pkg::CfgRuleStride);
    reg_access(1'b1, base, start_addr);
    reg_access(1'b1, base + 12'h4, end_addr);
    reg_access(1'b1, base + 12'h8, {24'b0, idx});
    reg_access(1'b0, base, '0);
    reg_access(1'b0, base + 12'h4, '0);
    reg_access(1'b0, base + 12'h8, '0);
  endtask

  // upstream transfer that collects psel_o while it runs
  task automatic bus_transfer(input logic write, input logic [AW-1:0] addr,
                              input logic [DW-1:0] wdata, output logic [DW-1:0] rdata,
                              output logic err, output logic [NoPorts-1:0] sel);
    int unsigned cycles;
    int unsigned sel_cycles;
    logic        got;
    rdata      = '0;
    err        = 1'b0;
    sel        = '0;
    got        = 1'b0;
    cycles     = 0;
    sel_cycles = 0;
    if (hung) return;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    while (!got && (cycles < ReadyTimeout)) begin
      @(negedge clk);
      sel = sel | ds_psel;
      if (|ds_psel) begin
        // setup phase first, then access phases with penable high
        check_value($sformatf("penable_o for %h", addr), 32'(ds_penable),
                    32'(sel_cycles != 0));
        check_value($sformatf("paddr_o for %h", addr), ds_paddr, addr);
        check_value($sformatf("pwrite_o for %h", addr), 32'(ds_pwrite), 32'(write));
        if (write) begin
          check_value($sformatf("pwdata_o for %h", addr), ds_pwdata, wdata);
        end
        sel_cycles++;
      end
      if (pready) begin
        got   = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end
      cycles++;
    end
    if (!got) begin
      $display("timeout at %0t ns: pready_o stayed low for %0d cycles", $time, ReadyTimeout);
      hung = 1'b1;
    end
    // keep the access open across the edge that completes it
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // returns the decode error and the port picked by priority
  function automatic logic route_port(input logic [AW-1:0] addr, output int unsigned port);
    logic hit;
    hit  = 1'b0;
    port = 0;
    for (int unsigned r = 0; r < NoRules; r++) begin
      if ((addr >= rule_start[r]) && (addr < rule_end[r])) begin
        hit  = 1'b1;
        port = rule_idx[r];
      end
    end
    if (!hit && def_en) begin
      hit  = 1'b1;
      port = def_idx;
    end
    return !hit;
  endfunction

  task automatic data_op(input logic write, input logic [AW-1:0] addr, input logic [DW-1:0] wdata);
    int unsigned        port;
    logic               dec_err;
    logic               range_err;
    logic [DW-1:0]      rdata;
    logic               err;
    logic [NoPorts-1:0] sel;
    logic [NoPorts-1:0] exp_sel;
    logic [DW-1:0]      exp_rdata;
    dec_err   = route_port(addr, port);
    range_err = (addr[9:2] >= 8'd64);
    exp_sel   = '0;
    if (!dec_err) begin
      exp_sel[port] = 1'b1;
    end
    exp_rdata = (dec_err || range_err) ? '0 : mem_model[port][addr[7:2]];
    bus_transfer(write, addr, wdata, rdata, err, sel);
    check_value($sformatf("psel_o for %h", addr), 32'(sel), 32'(exp_sel));
    check_value($sformatf("pslverr_o for %h", addr), 32'(err), 32'(dec_err || range_err));
    if (!write) begin
      check_value($sformatf("prdata_o for %h", addr), rdata, exp_rdata);
    end else if (!dec_err && !range_err) begin
      mem_model[port][addr[7:2]] = wdata;
    end
  endtask

  // read, write, read back at random word addresses in 0..32 KiB
  task automatic run_traffic(input int unsigned count);
    logic [AW-1:0] addr;
    logic [7:0]    word;
    for (int unsigned n = 0; n < count; n++) begin
      // one in eight words lands past the completer memory
      word = (($urandom % 8) == 0) ? 8'(64 + ($urandom % 192)) : 8'($urandom % 64);
      addr = {17'b0, 5'($urandom % 32), word, 2'b00};
      data_op(1'b0, addr, '0);
      data_op(1'b1, addr, $urandom);
      data_op(1'b0, addr, '0);
    end
  endtask

  initial begin
    void'($urandom(32'h3252));
    clk         = 1'b0;
    rst_n       = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    paddr       = '0;
    pwrite      = 1'b0;
    pwdata      = '0;
    cfg_psel    = 1'b0;
    cfg_penable = 1'b0;
    cfg_paddr   = '0;
    cfg_pwrite  = 1'b0;
    cfg_pwdata  = '0;
    errors      = 0;
    checks      = 0;
    hung        = 1'b0;
    def_en      = 1'b0;
    def_idx     = '0;
    for (int unsigned r = 0; r < NoRules; r++) begin
      rule_start[r] = '0;
      rule_end[r]   = '0;
      rule_idx[r]   = '0;
    end
    for (int unsigned p = 0; p < NoPorts; p++) begin
      for (int unsigned w = 0; w < 64; w++) begin
        mem_model[p][w] = fill_word(p, w);
      end
    end

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle outputs and an empty map after reset
    @(negedge clk);
    check_value("pready_o after reset", 32'(pready), '0);
    check_value("psel_o after reset", 32'(ds_psel), '0);
    check_value("penable_o after reset", 32'(ds_penable), '0);
    check_value("cfg_pslverr_o after reset", 32'(cfg_pslverr), '0);
    for (int unsigned r = 0; r < NoRules; r++) begin
      reg_access(1'b0, 12'(r * 16), '0);
      reg_access(1'b0, 12'(r * 16 + 4), '0);
      reg_access(1'b0, 12'(r * 16 + 8), '0);
    end
    reg_access(1'b0, apb_demux_pkg::CfgCtrlAddr, '0);

    // rule 0 spans 12 KiB and rules 1 and 2 overlap inside it
    program_rule(0, 32'h0000_0000, 32'h0000_3000, 8'd0);
    program_rule(1, 32'h0000_1000, 32'h0000_2000, 8'd1);
    program_rule(2, 32'h0000_1800, 32'h0000_2800, 8'd2);
    program_rule(3, 32'h0000_5000, 32'h0000_6000, 8'd1);

    // refused values and unmapped offsets leave the map intact
    reg_access(1'b1, 12'h018, 32'h0000_0004);
    reg_access(1'b1, 12'h038, 32'h0000_0100);
    reg_access(1'b0, 12'h018, '0);
    reg_access(1'b0, 12'h038, '0);
    reg_access(1'b1, 12'h00C, 32'hDEAD_BEEF);
    reg_access(1'b0, 12'h040, '0);
    reg_access(1'b0, 12'h104, '0);
    reg_access(1'b1, apb_demux_pkg::CfgCtrlAddr, 32'h0000_0501);
    reg_access(1'b0, apb_demux_pkg::CfgCtrlAddr, '0);

    // holes answer with an error while the default is off
    run_traffic(40);

    // default port 3 catches the holes
    reg_access(1'b1, apb_demux_pkg::CfgCtrlAddr, 32'h0000_0301);
    reg_access(1'b0, apb_demux_pkg::CfgCtrlAddr, '0);
    run_traffic(30);

    $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, hung);
    if ((errors == 0) && !hung) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
verilog/apb_demux_pkg.sv
verilog/apb_addr_decode.sv
verilog/apb_map_regs.sv
verilog/apb_req_stage.sv
verilog/apb_fwd_stage.sv
verilog/apb_demux_top.sv
verification/tb_apb_completer.sv
verification/tb_apb_demux.sv

/* Makefile */
# Verilator build and run of the APB demux testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_apb_demux -Mdir obj_dir -o sim_apb_demux
	./obj_dir/sim_apb_demux | tee sim.log
	@grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
